// ==== Bender.yml ====
package:
  name: mic_capture

export_include_dirs:
  - hdl

sources:
  - hdl/mic_pkg.sv
  - hdl/apb_regs_pkg.sv
  - hdl/fifo_if.sv
  - hdl/pdm_capture.sv
  - hdl/sample_fifo.sv
  - hdl/mic_apb_regs.sv
  - hdl/mic_capture_top.sv
  - target: test
    files:
      - testbench/mic_capture_sva.sv
      - testbench/tb_mic_capture.sv

// ==== hdl/apb_regs_pkg.sv ====
/* apb register map of the mic capture block
   register offsets and control/status word layouts */
`include "mic_params.svh"
`default_nettype none

package apb_regs_pkg;

   typedef enum logic [7:0] {
      REG_CTRL   = 8'h00,
      REG_STATUS = 8'h04,
      REG_DATA   = 8'h08
   } reg_addr_e;

   typedef struct packed {
      logic [28:0] rsvd;
      logic        ovf_clr;  // write 1 clears overflow
      logic        flush;    // self clearing
      logic        enable;
   } ctrl_t;

   typedef struct packed {
      logic [31-(`FIFO_ADR_W+5):0] rsvd_hi;
      logic [`FIFO_ADR_W:0]        level;
      logic                        rsvd_3;
      logic                        overflow;
      logic                        full;
      logic                        empty;
   } status_t;

endpackage

`default_nettype wire

// ==== hdl/fifo_if.sv ====
/* sample fifo access bundle
   push side from the front end, pop side for the register block */
`default_nettype none

interface fifo_if
   import mic_pkg::*;
();

   logic        push;
   sample_t     push_data;
   logic        pop;
   logic        flush;
   logic        ovf_clr;
   sample_t     pop_data;
   logic        empty;
   logic        full;
   fifo_level_t level;
   logic        overflow;

   modport fifo_side (
      input  push, push_data, pop, flush, ovf_clr,
      output pop_data, empty, full, level, overflow
   );

   modport reader (
      output pop, flush, ovf_clr,
      input  pop_data, empty, full, level, overflow
   );

endinterface

`default_nettype wire

// ==== hdl/mic_apb_regs.sv ====
/* apb register window of the mic capture block
   control, status and data registers, data reads pop the fifo */
`default_nettype none

module mic_apb_regs
   import apb_regs_pkg::*;
(
   input  logic        mclk,
   input  logic        reset,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   output logic        enable,
   fifo_if.reader      q
);

   reg_addr_e addr;
   ctrl_t     wr_ctrl;
   ctrl_t     rd_ctrl;
   status_t   status;
   logic      access;
   logic      ctrl_wr;

   assign access  = psel & penable;
   assign addr    = reg_addr_e'(paddr);
   assign wr_ctrl = ctrl_t'(pwdata);
   assign pready  = 1'b1;   // no wait states

   assign ctrl_wr = access & pwrite & (addr == REG_CTRL);

   // one cycle strobes, taken on the edge that ends the access phase
   assign q.flush   = ctrl_wr & wr_ctrl.flush;
   assign q.ovf_clr = ctrl_wr & wr_ctrl.ovf_clr;
   assign q.pop     = access & ~pwrite & (addr == REG_DATA) & ~q.empty;

   always_ff @(posedge mclk)
   begin
      if (reset)
         enable <= 1'b0;
      else if (ctrl_wr)
         enable <= wr_ctrl.enable;
   end

   // flush and ovf_clr always read back as 0
   always_comb
   begin
      rd_ctrl        = '0;
      rd_ctrl.enable = enable;
   end

   always_comb
   begin
      status          = '0;
      status.empty    = q.empty;
      status.full     = q.full;
      status.overflow = q.overflow;
      status.level    = q.level;
   end

   always_comb
   begin
      prdata  = '0;
      pslverr = 1'b0;
      if (access)
      begin
         case (addr)
            REG_CTRL:
            begin
               if (!pwrite)
                  prdata = rd_ctrl;
            end
            REG_STATUS:
            begin
               if (pwrite)
                  pslverr = 1'b1;   // read only
               else
                  prdata = status;
            end
            REG_DATA:
            begin
               if (pwrite || q.empty)
                  pslverr = 1'b1;   // empty read returns 0
               else
                  prdata = 32'(q.pop_data);
            end
            default: pslverr = 1'b1;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hdl/mic_capture_top.sv ====
/* pdm microphone capture top
   front end into the sample fifo, read out through apb registers */
`default_nettype none

module mic_capture_top
   import mic_pkg::*;
(
   input  logic        mclk,
   input  logic        reset,
   input  logic        mic_data,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [31:0] pwdata,
   output logic        mic_clk,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr
);

   fifo_if  q ();
   sample_t sample;
   logic    sample_valid;
   logic    enable;

   pdm_capture i_pdm_capture (
      .mclk         (mclk),
      .reset        (reset),
      .enable       (enable),
      .mic_data     (mic_data),
      .mic_clk      (mic_clk),
      .sample       (sample),
      .sample_valid (sample_valid)
   );

   // every finished window goes straight into the fifo
   assign q.push      = sample_valid;
   assign q.push_data = sample;

   sample_fifo i_sample_fifo (
      .mclk  (mclk),
      .reset (reset),
      .q     (q)
   );

   mic_apb_regs i_mic_apb_regs (
      .mclk    (mclk),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .enable  (enable),
      .q       (q)
   );

endmodule

`default_nettype wire

// ==== hdl/mic_params.svh ====
/* pdm capture constants
   mic clock divider, decimation window, sample width and fifo size */
`ifndef MIC_PARAMS_SVH
`define MIC_PARAMS_SVH
`default_nettype none

// mclk cycles per mic bit period
`define MIC_CLK_DIV 4
// pdm bits folded into one sample
`define PDM_DECIM 16
// wide enough for a count of 0..PDM_DECIM
`define SAMPLE_W 8
`define FIFO_ADR_W 3
`define FIFO_DEPTH (1 << `FIFO_ADR_W)

`default_nettype wire
`endif

// ==== hdl/mic_pkg.sv ====
/* audio side types
   samples and fifo fill level shared by front end, fifo and interface */
`include "mic_params.svh"
`default_nettype none

package mic_pkg;

   // one decimated sample, ones count of a window
   typedef logic [`SAMPLE_W-1:0] sample_t;

   // one bit wider than the address so a full fifo fits
   typedef logic [`FIFO_ADR_W:0] fifo_level_t;

endpackage

`default_nettype wire

// ==== hdl/pdm_capture.sv ====
/* pdm microphone front end
   bit clock from mclk, one sample per window as a count of ones */
`include "mic_params.svh"
`default_nettype none

module pdm_capture
   import mic_pkg::*;
(
   input  logic    mclk,
   input  logic    reset,
   input  logic    enable,
   input  logic    mic_data,
   output logic    mic_clk,
   output sample_t sample,
   output logic    sample_valid
);

   localparam int DIV_W = $clog2(`MIC_CLK_DIV);
   localparam int BIT_W = $clog2(`PDM_DECIM);

   logic [DIV_W-1:0] div_cnt;
   logic [BIT_W-1:0] bit_cnt;   // bits taken in the current window
   sample_t          ones_cnt;
   logic             bit_tick;
   logic             last_bit;

   // high for the first half of the bit period
   assign mic_clk = enable & (div_cnt < DIV_W'(`MIC_CLK_DIV / 2));

   // count 0 is the cycle after the mic_clk rising edge
   assign bit_tick = enable & (div_cnt == '0);
   assign last_bit = bit_tick & (bit_cnt == BIT_W'(`PDM_DECIM - 1));

   always_ff @(posedge mclk)
   begin
      if (reset || !enable)
         div_cnt <= '0;
      else if (div_cnt == DIV_W'(`MIC_CLK_DIV - 1))
         div_cnt <= '0;
      else
         div_cnt <= div_cnt + 1'b1;
   end

   always_ff @(posedge mclk)
   begin
      if (reset || !enable)
      begin
         bit_cnt  <= '0;
         ones_cnt <= '0;
      end
      else if (last_bit)
      begin
         bit_cnt  <= '0;   // next window starts empty
         ones_cnt <= '0;
      end
      else if (bit_tick)
      begin
         bit_cnt  <= bit_cnt + 1'b1;
         ones_cnt <= ones_cnt + sample_t'(mic_data);
      end
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
         sample_valid <= 1'b0;
      else
         sample_valid <= last_bit;
   end

   // last bit of the window folded in here
   always_ff @(posedge mclk)
   begin
      if (last_bit)
         sample <= ones_cnt + sample_t'(mic_data);
   end

endmodule

`default_nettype wire

// ==== hdl/sample_fifo.sv ====
/* circular sample fifo, first word fall through
   drops pushes when full and keeps a sticky overflow flag */
`include "mic_params.svh"
`default_nettype none

module sample_fifo
   import mic_pkg::*;
(
   input logic   mclk,
   input logic   reset,
   fifo_if.fifo_side q
);

   localparam int DEPTH = `FIFO_DEPTH;

   sample_t                mem [DEPTH];
   logic [`FIFO_ADR_W-1:0] wr_ptr;
   logic [`FIFO_ADR_W-1:0] rd_ptr;
   fifo_level_t            level_r;
   logic                   overflow_r;
   logic                   do_push;
   logic                   do_pop;
   logic                   drop;

   assign q.empty    = (level_r == '0);
   assign q.full     = (level_r == fifo_level_t'(DEPTH));
   assign q.level    = level_r;
   assign q.overflow = overflow_r;
   assign q.pop_data = mem[rd_ptr];   // oldest entry, no read latency

   // full wins over a pop in the same cycle, so the push is lost
   assign do_push = q.push & ~q.full;
   assign do_pop  = q.pop & ~q.empty;
   assign drop    = q.push & q.full;

   always_ff @(posedge mclk)
   begin
      if (do_push)
         mem[wr_ptr] <= q.push_data;
   end

   always_ff @(posedge mclk)
   begin
      if (reset || q.flush)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         level_r <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   level_r <= level_r + 1'b1;
            2'b01:   level_r <= level_r - 1'b1;
            default: level_r <= level_r;
         endcase
      end
   end

   // sticky, a drop in the clearing cycle still counts
   always_ff @(posedge mclk)
   begin
      if (reset)
         overflow_r <= 1'b0;
      else if (drop)
         overflow_r <= 1'b1;
      else if (q.ovf_clr)
         overflow_r <= 1'b0;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hdl
hdl/mic_pkg.sv
hdl/apb_regs_pkg.sv
hdl/fifo_if.sv
hdl/pdm_capture.sv
hdl/sample_fifo.sv
hdl/mic_apb_regs.sv
hdl/mic_capture_top.sv
testbench/mic_capture_sva.sv
testbench/tb_mic_capture.sv

// ==== testbench/mic_capture_sva.sv ====
/* concurrent checks on the sample fifo and the apb port
   bound into the mic capture top */
`include "mic_params.svh"
`default_nettype none

module mic_capture_sva
   import mic_pkg::*;
(
   input logic        mclk,
   input logic        reset,
   input logic        push,
   input logic        pop,
   input logic        flush,
   input logic        full,
   input logic        empty,
   input fifo_level_t level,
   input logic        psel,
   input logic        penable,
   input logic        pready
);

   // a dropped push with nothing else going on leaves the level alone
   a_drop_hold: assert property (@(posedge mclk) disable iff (reset)
      (push && full && !pop && !flush) |=> (level == $past(level)))
      else $error("fifo level moved on a dropped push");

   a_not_empty_full: assert property (@(posedge mclk) disable iff (reset)
      !(empty && full))
      else $error("fifo reports empty and full together");

   a_pready: assert property (@(posedge mclk) disable iff (reset)
      (psel && penable) |-> pready)
      else $error("pready low in an apb access phase");

   a_level_max: assert property (@(posedge mclk) disable iff (reset)
      level <= fifo_level_t'(`FIFO_DEPTH))
      else $error("fifo level above depth");

endmodule

// fifo signals reached through the interface instance of the top
bind mic_capture_top mic_capture_sva i_mic_capture_sva (
   .mclk    (mclk),
   .reset   (reset),
   .push    (q.push),
   .pop     (q.pop),
   .flush   (q.flush),
   .full    (q.full),
   .empty   (q.empty),
   .level   (q.level),
   .psel    (psel),
   .penable (penable),
   .pready  (pready)
);

`default_nettype wire

// ==== testbench/tb_mic_capture.sv ====
/* testbench of the pdm capture block
   random pdm source, apb driver and a queue model of the sample fifo */
`include "mic_params.svh"
`default_nettype none

module tb_mic_capture
   import apb_regs_pkg::*;
();

   localparam int DEPTH = `FIFO_DEPTH;
   // about 40 samples of 64 mclk plus apb traffic and slack
   localparam int MAX_CYCLES = 20000;

   logic        mclk;
   logic        reset;
   logic        mic_data;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic        mic_clk;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;

   // reference model state
   logic [7:0]  mq [$];
   logic        m_ovf;
   logic        mic_clk_d;
   int          win_cnt;
   int          win_ones;
   int          pend_cnt;      // falling edges until a finished window lands in the fifo
   logic [7:0]  pend_val;
   int          samp_total;
   int          density;       // ones per 16 bits, roughly
   int          rise_gap;      // mclk cycles since the last mic_clk rise
   int          high_len;      // cycles mic_clk has been high
   logic        pop_req;
   logic        flush_req;
   logic        clr_req;
   int          snap_size;     // model view during the last access phase
   logic [7:0]  snap_front;
   logic        snap_ovf;
   int          cycle_cnt = 0;
   int          err_cnt = 0;

   mic_capture_top i_mic_capture_top (
      .mclk     (mclk),
      .reset    (reset),
      .mic_data (mic_data),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .mic_clk  (mic_clk),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr)
   );

   always #20 mclk = ~mclk;

   always @(posedge mclk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout: test sequence did not finish within %0d cycles", MAX_CYCLES);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   end

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("ERR %s got %h expected %h", name, got, exp);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   // model applies on the falling edge what the last rising edge did
   always @(negedge mclk)
   begin
      logic push_now;
      logic was_full;
      push_now = (pend_cnt == 1);
      if (pend_cnt != 0)
         pend_cnt--;
      was_full = (mq.size() == DEPTH);
      if (flush_req)
         mq.delete();
      else
      begin
         if (pop_req && mq.size() != 0)
            void'(mq.pop_front());
         if (push_now && !was_full)
            mq.push_back(pend_val);
      end
      if (push_now && was_full)
         m_ovf = 1'b1;   // dropped sample
      else if (clr_req)
         m_ovf = 1'b0;
      if (push_now)
         samp_total++;
      pop_req   = 1'b0;
      flush_req = 1'b0;
      clr_req   = 1'b0;
      if (mic_clk && !mic_clk_d)
      begin
         if (rise_gap > 0)
            check_val("mic_clk period", rise_gap, `MIC_CLK_DIV);
         rise_gap = 0;
         high_len = 1;
      end
      else if (mic_clk)
         high_len++;
      if (!mic_clk && mic_clk_d)
         check_val("mic_clk high time", high_len, `MIC_CLK_DIV / 2);
      if (rise_gap >= 0)
         rise_gap++;
      if (mic_clk && !mic_clk_d)
      begin
         win_ones += mic_data;   // dut takes this bit on the next rising edge
         win_cnt++;
         if (win_cnt == `PDM_DECIM)
         begin
            pend_val = win_ones[7:0];
            pend_cnt = 2;
            win_cnt  = 0;
            win_ones = 0;
         end
      end
      if (!mic_clk && mic_clk_d)
         mic_data = (($urandom % 16) < density);   // new pdm bit
      mic_clk_d = mic_clk;
   end

   task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      @(negedge mclk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge mclk);
      penable = 1'b1;
      @(posedge mclk);
      rdata      = prdata;
      err        = pslverr;
      snap_size  = mq.size();
      snap_front = (mq.size() != 0) ? mq[0] : 8'h00;
      snap_ovf   = m_ovf;
      check_val("pready", pready, 1);
      if (!wr && addr == REG_DATA)
         pop_req = 1'b1;
      if (wr && addr == REG_CTRL)
      begin
         flush_req = wdata[1];
         clr_req   = wdata[2];
      end
      @(negedge mclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic write_ctrl(input logic [31:0] wdata);
      logic [31:0] rdata;
      logic        err;
      apb_xfer(1'b1, REG_CTRL, wdata, rdata, err);
      check_val("pslverr", err, 0);
   endtask

   task automatic read_data_check();
      logic [31:0] rdata;
      logic        err;
      apb_xfer(1'b0, REG_DATA, 32'h0, rdata, err);
      if (snap_size != 0)
      begin
         check_val("prdata", rdata, {24'h0, snap_front});
         check_val("pslverr", err, 0);
      end
      else
      begin
         check_val("prdata", rdata, 32'h0);   // empty read
         check_val("pslverr", err, 1);
      end
   endtask

   task automatic read_status_check(output logic [31:0] st);
      logic [31:0] exp;
      logic        err;
      apb_xfer(1'b0, REG_STATUS, 32'h0, st, err);
      exp      = '0;
      exp[0]   = (snap_size == 0);
      exp[1]   = (snap_size == DEPTH);
      exp[2]   = snap_ovf;
      exp[7:4] = snap_size[3:0];
      check_val("status", st, exp);
      check_val("pslverr", err, 0);
   endtask

   // reads until one read finds the fifo empty
   task automatic drain_fifo();
      read_data_check();
      while (snap_size != 0)
         read_data_check();
   endtask

   task automatic wait_samples(input int n);
      int target;
      target = samp_total + n;
      while (samp_total < target)
         @(posedge mclk);
   endtask

   initial
   begin
      logic [31:0] st;
      logic [31:0] rdata;
      logic        err;
      void'($urandom(44377));
      mclk       = 1'b0;
      reset      = 1'b1;
      mic_data   = 1'b0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = 8'h00;
      pwdata     = 32'h0;
      m_ovf      = 1'b0;
      mic_clk_d  = 1'b0;
      win_cnt    = 0;
      win_ones   = 0;
      pend_cnt   = 0;
      pend_val   = 8'h00;
      samp_total = 0;
      rise_gap   = -1;
      high_len   = 0;
      pop_req    = 1'b0;
      flush_req  = 1'b0;
      clr_req    = 1'b0;
      density    = 8;
      repeat (10) @(negedge mclk);
      reset = 1'b0;

      // no bit clock while idle after reset
      read_status_check(st);
      check_val("status", st, 32'h1);
      repeat (16)
      begin
         @(posedge mclk);
         check_val("mic_clk", mic_clk, 0);
      end

      // decimation
      density = $urandom % 17;
      write_ctrl(32'h1);
      wait_samples(4);
      drain_fifo();

      // fifo left unread past its depth overflows
      density = $urandom % 17;
      wait_samples(DEPTH + 2);
      read_status_check(st);
      check_val("full", st[1], 1);
      check_val("overflow", st[2], 1);
      repeat (DEPTH) read_data_check();
      write_ctrl(32'h5);
      read_status_check(st);
      check_val("overflow", st[2], 0);

      // empty read and bad accesses
      drain_fifo();
      apb_xfer(1'b1, REG_STATUS, 32'hff, rdata, err);
      check_val("pslverr", err, 1);
      apb_xfer(1'b0, 8'h0c, 32'h0, rdata, err);
      check_val("pslverr", err, 1);
      apb_xfer(1'b1, REG_DATA, 32'h5a, rdata, err);
      check_val("pslverr", err, 1);

      // flush keeps capture running
      density = $urandom % 17;
      wait_samples(3);
      write_ctrl(32'h3);
      read_status_check(st);
      check_val("level", st[7:4], 0);
      wait_samples(2);
      drain_fifo();

      // level tracked over random reads and waits
      repeat (40)
      begin
         density = $urandom % 17;
         case ($urandom % 3)
            0: repeat ($urandom % 48) @(posedge mclk);
            1: read_data_check();
            default:
            begin
               repeat ($urandom % 96) @(posedge mclk);
               read_data_check();
            end
         endcase
         read_status_check(st);
      end

      if (err_cnt == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire
